//--- trace_unit.f
rtl/trace_pkg.sv
rtl/nop_decoder.sv
rtl/event_arbiter.sv
rtl/termination_tracker.sv
rtl/trace_unit.sv
tests/tb_trace_unit.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the trace unit and its testbench with Verilator and runs the simulation
# Pass or fail comes from the messages printed by the testbench
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_trace_unit \
   --Mdir obj_dir -f trace_unit.f

# A failing run exits nonzero, the search below decides the result
output=$(./obj_dir/Vtb_trace_unit 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

//--- tests/tb_trace_unit.sv
`default_nettype none
//********************
// Testbench for the trace unit with three cores
// Random per-core traces checked against a cycle model
//********************

module tb_trace_unit;

   localparam int unsigned NUM_CORES  = 3;
   localparam int unsigned CLK_PERIOD = 4;
   localparam int unsigned RST_CYCLES = 4;
   localparam int unsigned SEED       = 32'hf044bf68;

   // Phase lengths in cycles
   localparam int unsigned SOLO_LEN   = 16;
   localparam int unsigned CONT_LEN   = 60;
   localparam int unsigned RAND_B_LEN = 24;
   localparam int unsigned JUNK_LEN   = 4;
   localparam int unsigned GAP_LEN    = 6;
   localparam int unsigned EXIT_LEN   = 2 + JUNK_LEN + GAP_LEN;
   localparam int unsigned TOTAL_CYCLES = 2 * RST_CYCLES + NUM_CORES * SOLO_LEN + CONT_LEN
                                        + RAND_B_LEN + 2 * NUM_CORES * EXIT_LEN + 10 * GAP_LEN;
   // 50 spare cycles on top
   localparam int unsigned WATCHDOG_TIME = (TOTAL_CYCLES + 50) * CLK_PERIOD;

   // l.nop immediates that are no command
   localparam logic [15:0] PLAIN_IMM [4] = '{16'h0000, 16'h0003, 16'h0005, 16'h0102};

   logic                              clk = 1'b0;
   logic                              arst_n_i;
   trace_pkg::trace_t [NUM_CORES-1:0] trace;
   trace_pkg::sim_event_t             event_o;
   logic [NUM_CORES-1:0]              overflow_o;
   logic [NUM_CORES-1:0]              exited_o;
   logic                              done_o;
   logic                              fail_o;

   // Reference model state
   logic [31:0]           m_r3 [NUM_CORES];
   // Decoder lock-out once an exit is taken
   bit                    m_lock [NUM_CORES];
   trace_pkg::sim_event_t m_pend [NUM_CORES];
   bit                    m_exit_v [NUM_CORES];
   logic [31:0]           m_exit_code [NUM_CORES];
   logic [NUM_CORES-1:0]  m_over;
   logic [NUM_CORES-1:0]  m_exited;
   bit                    m_fail;
   int unsigned           m_last;
   trace_pkg::sim_event_t m_out;
   // Expected events per core with the oldest first
   trace_pkg::sim_event_t exp_q [NUM_CORES][$];
   int unsigned           n_events = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   trace_unit #(
      .NUM_CORES (NUM_CORES)
   ) dut_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .trace_i    (trace),
      .event_o    (event_o),
      .overflow_o (overflow_o),
      .exited_o   (exited_o),
      .done_o     (done_o),
      .fail_o     (fail_o)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_event(input string name, input trace_pkg::sim_event_t got,
                              input trace_pkg::sim_event_t want);
      if (got !== want) begin
         abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, want));
      end
   endtask

   task automatic check_bits(input string name, input logic [NUM_CORES-1:0] got,
                             input logic [NUM_CORES-1:0] want);
      if (got !== want) begin
         abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, want));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      if (got !== want) begin
         abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, want));
      end
   endtask

   function automatic void reset_model();
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         m_r3[c]        = '0;
         m_lock[c]      = 1'b0;
         m_pend[c]      = '0;
         m_exit_v[c]    = 1'b0;
         m_exit_code[c] = '0;
         exp_q[c].delete();
      end
      m_over   = '0;
      m_exited = '0;
      m_fail   = 1'b0;
      m_out    = '0;
      // Core 0 goes first after reset
      m_last   = NUM_CORES - 1;
   endfunction

   // One clock edge of the whole unit with the beats sampled at that edge
   function automatic void step_model(input trace_pkg::trace_t [NUM_CORES-1:0] beats);
      int unsigned           cand;
      int unsigned           gnt;
      bit                    found;
      bit                    beat;
      bit                    is_cmd;
      bit                    slot_free;
      bit                    load;
      logic [15:0]           imm;
      trace_pkg::sim_event_t ev;
      found = 1'b0;
      gnt   = 0;
      // Round robin from the core after the last grant
      for (int unsigned k = 1; k <= NUM_CORES; k++) begin
         cand = (m_last + k) % NUM_CORES;
         if (!found && m_pend[cand].valid) begin
            found = 1'b1;
            gnt   = cand;
         end
      end
      // Tracker sees the exit pulses of the previous edge
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         if (m_exit_v[c] && !m_exited[c]) begin
            m_exited[c] = 1'b1;
            if (m_exit_code[c] != '0) begin
               m_fail = 1'b1;
            end
         end
      end
      if (found) begin
         m_out = m_pend[gnt];
      end else begin
         m_out.valid = 1'b0;
      end
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         beat   = beats[c].valid && !m_lock[c];
         imm    = beats[c].insn[15:0];
         is_cmd = beat && (beats[c].insn[31:24] == trace_pkg::NOP_OPCODE)
                  && (imm == trace_pkg::CMD_EXIT || imm == trace_pkg::CMD_REPORT
                      || imm == trace_pkg::CMD_PUTC);
         // Entry is free when empty or granted in this cycle
         slot_free = !m_pend[c].valid || (found && gnt == c);
         load      = is_cmd && slot_free;
         m_exit_v[c]    = load && (imm == trace_pkg::CMD_EXIT);
         m_exit_code[c] = m_r3[c];
         if (is_cmd && !slot_free) begin
            m_over[c] = 1'b1;
         end
         if (load) begin
            ev.valid  = 1'b1;
            ev.cmd    = trace_pkg::sim_cmd_e'(imm);
            ev.core   = c[trace_pkg::CORE_ID_W-1:0];
            // Old r3 since a same-beat write lands afterwards
            ev.data   = m_r3[c];
            m_pend[c] = ev;
            exp_q[c].push_back(ev);
            if (imm == trace_pkg::CMD_EXIT) begin
               m_lock[c] = 1'b1;
            end
         end else if (found && gnt == c) begin
            m_pend[c].valid = 1'b0;
         end
         if (beat && beats[c].wben && beats[c].wbreg == 5'd3) begin
            m_r3[c] = beats[c].wbdata;
         end
      end
      if (found) begin
         m_last = gnt;
      end
   endfunction

   task automatic compare_outputs();
      trace_pkg::sim_event_t head;
      check_flag("event_o.valid", event_o.valid, m_out.valid);
      if (m_out.valid) begin
         // Round-robin pick names the core whose oldest event leaves now
         head = exp_q[m_out.core].pop_front();
         check_event("event_o", event_o, head);
         n_events++;
      end
      check_bits("overflow_o", overflow_o, m_over);
      check_bits("exited_o", exited_o, m_exited);
      check_flag("done_o", done_o, &m_exited);
      check_flag("fail_o", fail_o, m_fail);
   endtask

   // Compare process
   initial begin
      reset_model();
      forever begin
         @(posedge clk);
         // Outputs have settled and inputs still hold the sampled beats
         #1;
         if (!arst_n_i) begin
            reset_model();
         end else begin
            step_model(trace);
         end
         compare_outputs();
      end
   end

   function automatic trace_pkg::trace_t nop_beat(input logic [15:0] imm);
      trace_pkg::trace_t b;
      b       = '0;
      b.valid = 1'b1;
      b.pc    = $urandom & 32'hffff_fffc;
      b.insn  = {trace_pkg::NOP_OPCODE, 8'h00, imm};
      return b;
   endfunction

   function automatic trace_pkg::trace_t r3_write_beat(input logic [31:0] data);
      trace_pkg::trace_t b;
      b        = '0;
      b.valid  = 1'b1;
      b.pc     = $urandom & 32'hffff_fffc;
      // Any major opcode but l.nop
      b.insn   = {8'he0, 24'($urandom)};
      b.wben   = 1'b1;
      b.wbreg  = 5'd3;
      b.wbdata = data;
      return b;
   endfunction

   // busy is the percentage of valid beats
   function automatic trace_pkg::trace_t random_beat(input int unsigned busy);
      trace_pkg::trace_t b;
      int unsigned       roll;
      logic [1:0]        pick;
      roll = $urandom_range(99);
      if (roll >= busy) begin
         // Invalid beat that looks like a putc with an r3 write
         b        = nop_beat(trace_pkg::CMD_PUTC);
         b.valid  = 1'b0;
         b.wben   = 1'b1;
         b.wbreg  = 5'd3;
         b.wbdata = $urandom;
         return b;
      end
      roll = $urandom_range(99);
      pick = 2'($urandom_range(3));
      if (roll < 30) begin
         b = r3_write_beat($urandom);
      end else if (roll < 45) begin
         b       = r3_write_beat($urandom);
         b.wbreg = 5'($urandom_range(31));
         if (b.wbreg == 5'd3) begin
            b.wbreg = 5'd13;
         end
      end else if (roll < 60) begin
         b = nop_beat(PLAIN_IMM[pick]);
      end else if (roll < 78) begin
         b = nop_beat(trace_pkg::CMD_REPORT);
      end else if (roll < 96) begin
         b = nop_beat(trace_pkg::CMD_PUTC);
      end else begin
         // Command with an r3 write in the same beat
         b        = nop_beat(trace_pkg::CMD_REPORT);
         b.wben   = 1'b1;
         b.wbreg  = 5'd3;
         b.wbdata = $urandom;
      end
      return b;
   endfunction

   task automatic drive_beats(input trace_pkg::trace_t [NUM_CORES-1:0] beats);
      @(negedge clk);
      trace = beats;
   endtask

   task automatic idle_cycles(input int unsigned n);
      repeat (n) drive_beats('0);
   endtask

   task automatic random_cycles(input int unsigned n, input logic [NUM_CORES-1:0] mask,
                                input int unsigned busy);
      trace_pkg::trace_t [NUM_CORES-1:0] beats;
      for (int unsigned k = 0; k < n; k++) begin
         beats = '0;
         for (int unsigned c = 0; c < NUM_CORES; c++) begin
            if (mask[c]) begin
               beats[c] = random_beat(busy);
            end
         end
         drive_beats(beats);
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      arst_n_i = 1'b0;
      trace    = '0;
      repeat (RST_CYCLES) @(negedge clk);
      arst_n_i = 1'b1;
   endtask

   // Writes the exit code to r3 and exits before traffic that must be ignored
   task automatic exit_core(input int unsigned c, input logic [31:0] code);
      trace_pkg::trace_t [NUM_CORES-1:0] beats;
      beats    = '0;
      beats[c] = r3_write_beat(code);
      drive_beats(beats);
      beats[c] = nop_beat(trace_pkg::CMD_EXIT);
      drive_beats(beats);
      for (int unsigned k = 0; k < JUNK_LEN; k++) begin
         beats    = '0;
         beats[c] = random_beat(100);
         drive_beats(beats);
      end
      idle_cycles(GAP_LEN);
   endtask

   // Watchdog
   initial begin
      #(WATCHDOG_TIME);
      abort_run($sformatf("Run timed out at %0t before the tests finished", $time));
   end

   initial begin
      trace_pkg::trace_t [NUM_CORES-1:0] beats;
      logic [NUM_CORES-1:0]              mask;
      void'($urandom(SEED));
      arst_n_i = 1'b0;
      trace    = '0;
      apply_reset();
      // One active core at a time without contention
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         mask    = '0;
         mask[c] = 1'b1;
         random_cycles(SOLO_LEN, mask, 75);
      end
      idle_cycles(GAP_LEN);
      // All cores report in the same beat
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         beats[c] = r3_write_beat(32'h5a00_0000 | c);
      end
      drive_beats(beats);
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         beats[c] = nop_beat(trace_pkg::CMD_REPORT);
      end
      drive_beats(beats);
      idle_cycles(GAP_LEN);
      // Dense traffic on every core
      random_cycles(CONT_LEN, '1, 90);
      idle_cycles(GAP_LEN);
      // Back-to-back commands everywhere force drops
      for (int unsigned k = 0; k < 3; k++) begin
         for (int unsigned c = 0; c < NUM_CORES; c++) begin
            beats[c] = nop_beat(trace_pkg::CMD_PUTC);
         end
         drive_beats(beats);
      end
      idle_cycles(GAP_LEN);
      check_flag("overflow_o any", |overflow_o, 1'b1);
      // Core 1 leaves with a nonzero code
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         exit_core(c, (c == 1) ? ($urandom | 32'h1) : 32'h0);
      end
      check_flag("done_o", done_o, 1'b1);
      check_flag("fail_o", fail_o, 1'b1);
      // Second segment with clean exits only
      apply_reset();
      random_cycles(RAND_B_LEN, '1, 60);
      idle_cycles(GAP_LEN);
      for (int unsigned c = 0; c < NUM_CORES; c++) begin
         exit_core(c, 32'h0);
      end
      check_flag("done_o", done_o, 1'b1);
      check_flag("fail_o", fail_o, 1'b0);
      $display("Events checked: %0d", n_events);
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/trace_unit.sv
`default_nettype none
//********************
// Simulation-command monitor for a multi-core tile
// One trace per core in, one event stream and exit status out
//********************

module trace_unit #(
   // Cores in the tile, at most 256
   parameter int unsigned NUM_CORES = 2
) (
   input  wire                                  clk,
   input  wire                                  arst_n_i,
   // Writeback traces from the cores
   input  wire trace_pkg::trace_t [NUM_CORES-1:0] trace_i,
   // Decoded commands, one per cycle at most
   output trace_pkg::sim_event_t                event_o,
   // Dropped command per core, sticky
   output logic [NUM_CORES-1:0]                 overflow_o,
   output logic [NUM_CORES-1:0]                 exited_o,
   output logic                                 done_o,
   output logic                                 fail_o
);

   // Decoder to arbiter
   trace_pkg::sim_event_t [NUM_CORES-1:0] pend;
   logic [NUM_CORES-1:0]                  grant;

   // Decoder to tracker
   trace_pkg::exit_t [NUM_CORES-1:0]      exits;

   // One decoder per core
   for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
      nop_decoder #(
         .CORE_ID (c)
      ) u_nop_decoder (
         .clk        (clk),
         .arst_n_i   (arst_n_i),
         .trace_i    (trace_i[c]),
         .grant_i    (grant[c]),
         .pend_o     (pend[c]),
         .exit_o     (exits[c]),
         .overflow_o (overflow_o[c])
      );
   end

   // Shared event port
   event_arbiter #(
      .NUM_CORES (NUM_CORES)
   ) u_event_arbiter (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .pend_i   (pend),
      .grant_o  (grant),
      .event_o  (event_o)
   );

   // Exit bookkeeping
   termination_tracker #(
      .NUM_CORES (NUM_CORES)
   ) u_termination_tracker (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .exit_i   (exits),
      .exited_o (exited_o),
      .done_o   (done_o),
      .fail_o   (fail_o)
   );

endmodule

`default_nettype wire

//--- rtl/termination_tracker.sv
`default_nettype none
//********************
// Termination tracking across all cores
// Sticky exited bits, all-done and overall failure
//********************

module termination_tracker #(
   parameter int unsigned NUM_CORES = 2
) (
   input  wire                                   clk,
   input  wire                                   arst_n_i,
   // Exit pulses from the decoders
   input  wire trace_pkg::exit_t [NUM_CORES-1:0] exit_i,
   output logic [NUM_CORES-1:0]                  exited_o,
   output logic                                  done_o,
   output logic                                  fail_o
);

   // One bit per core
   logic [NUM_CORES-1:0] exited_q;
   // Core left with a nonzero code
   logic [NUM_CORES-1:0] nonzero_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         exited_q  <= '0;
         nonzero_q <= '0;
      end else begin
         for (int unsigned c = 0; c < NUM_CORES; c++) begin
            // First exit of a core counts, later ones do not
            if (exit_i[c].valid && !exited_q[c]) begin
               exited_q[c]  <= 1'b1;
               nonzero_q[c] <= |exit_i[c].code;
            end
         end
      end
   end

   assign exited_o = exited_q;

   // Rises together with the last exited bit
   assign done_o = &exited_q;

   // Meaningful once done_o is high
   assign fail_o = |nonzero_q;

endmodule

`default_nettype wire

//--- rtl/event_arbiter.sv
`default_nettype none
//********************
// Round-robin arbiter over the per-core pending events
// Grants one core per cycle, event leaves one cycle later
//********************

module event_arbiter #(
   parameter int unsigned NUM_CORES = 2
) (
   input  wire                                        clk,
   input  wire                                        arst_n_i,
   // Pending entries, one per core
   input  wire trace_pkg::sim_event_t [NUM_CORES-1:0] pend_i,
   output logic [NUM_CORES-1:0]                       grant_o,
   output trace_pkg::sim_event_t                      event_o
);

   localparam int unsigned IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

   // Last granted core
   logic [IDX_W-1:0]      last_q;
   logic [IDX_W-1:0]      sel;
   logic                  found;

   // Registered output
   logic                  ev_valid_q;
   trace_pkg::sim_event_t ev_q;

   // Search starts at the core after last_q and wraps
   always_comb begin
      int unsigned cand;
      found   = 1'b0;
      sel     = last_q;
      grant_o = '0;
      for (int unsigned k = 1; k <= NUM_CORES; k++) begin
         cand = int'(last_q) + k;
         if (cand >= NUM_CORES) begin
            cand = cand - NUM_CORES;
         end
         if (!found && pend_i[cand].valid) begin
            found = 1'b1;
            sel   = IDX_W'(cand);
         end
      end
      if (found) begin
         grant_o[sel] = 1'b1;
      end
   end

   // Pointer starts on the last core so core 0 goes first
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         last_q     <= IDX_W'(NUM_CORES - 1);
         ev_valid_q <= 1'b0;
      end else begin
         ev_valid_q <= found;
         if (found) begin
            last_q <= sel;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (found) begin
         ev_q <= pend_i[sel];
      end
   end

   // Valid is a single-cycle pulse per grant
   always_comb begin
      event_o       = ev_q;
      event_o.valid = ev_valid_q;
   end

endmodule

`default_nettype wire

//--- rtl/nop_decoder.sv
`default_nettype none
//********************
// Per-core l.nop command decoder
// Shadows r3 and holds one pending event until the arbiter grants it
//********************

module nop_decoder #(
   // Core index stamped into every event
   parameter int unsigned CORE_ID = 0
) (
   input  wire                       clk,
   input  wire                       arst_n_i,
   // Writeback trace of this core
   input  wire trace_pkg::trace_t    trace_i,
   // Pending entry taken this cycle
   input  wire                       grant_i,
   output trace_pkg::sim_event_t     pend_o,
   output trace_pkg::exit_t          exit_o,
   output logic                      overflow_o
);

   localparam logic [trace_pkg::CORE_ID_W-1:0] CORE_IDX =
      CORE_ID[trace_pkg::CORE_ID_W-1:0];

   // Control state
   logic                exited_q;
   logic                pend_valid_q;
   logic                exit_pulse_q;
   logic                overflow_q;
   logic [31:0]         r3_q;

   // Pending payload
   trace_pkg::sim_cmd_e pend_cmd_q;
   logic [31:0]         pend_data_q;

   // Beat decode
   logic [15:0]         imm;
   logic                beat;
   logic                is_cmd;
   logic                is_exit;
   logic                slot_free;
   logic                load;
   logic                drop;
   logic                r3_we;

   // Beats after exit are dead
   assign beat = trace_i.valid & ~exited_q;
   assign imm  = trace_i.insn[15:0];

   // l.nop with one of the known immediates
   assign is_cmd = beat
                 & (trace_i.insn[31:24] == trace_pkg::NOP_OPCODE)
                 & (imm inside {trace_pkg::CMD_EXIT,
                                trace_pkg::CMD_REPORT,
                                trace_pkg::CMD_PUTC});
   assign is_exit = (imm == trace_pkg::CMD_EXIT);

   // Entry frees up when empty or when granted this cycle
   assign slot_free = ~pend_valid_q | grant_i;
   assign load      = is_cmd & slot_free;
   assign drop      = is_cmd & ~slot_free;

   // Writeback into r3
   assign r3_we = beat & trace_i.wben & (trace_i.wbreg == 5'd3);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r3_q         <= '0;
         exited_q     <= 1'b0;
         pend_valid_q <= 1'b0;
         exit_pulse_q <= 1'b0;
         overflow_q   <= 1'b0;
      end else begin
         // Same-beat command still reads the old r3_q
         if (r3_we) begin
            r3_q <= trace_i.wbdata;
         end
         // Load wins over the grant clear
         if (load) begin
            pend_valid_q <= 1'b1;
         end else if (grant_i) begin
            pend_valid_q <= 1'b0;
         end
         // Exit pulse lines up with the event load
         exit_pulse_q <= load & is_exit;
         if (load && is_exit) begin
            exited_q <= 1'b1;
         end
         // Sticky until reset
         if (drop) begin
            overflow_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         pend_cmd_q  <= trace_pkg::sim_cmd_e'(imm);
         pend_data_q <= r3_q;
      end
   end

   assign pend_o = '{valid: pend_valid_q,
                     cmd:   pend_cmd_q,
                     core:  CORE_IDX,
                     data:  pend_data_q};

   // Exit code is the r3 captured with the exit event
   assign exit_o = '{valid: exit_pulse_q,
                     code:  pend_data_q};

   assign overflow_o = overflow_q;

endmodule

`default_nettype wire

//--- rtl/trace_pkg.sv
`default_nettype none
//********************
// Shared types for the simulation-command trace unit
// Trace beats, l.nop commands, events and exit records
//********************

package trace_pkg;

   // Width of a core index in an event
   localparam int CORE_ID_W = 8;

   // Major opcode of l.nop, top byte of the instruction word
   localparam logic [7:0] NOP_OPCODE = 8'h15;

   // One retired instruction from a core's writeback stage
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      // Register write at retirement
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } trace_t;

   // l.nop immediates understood as simulation commands
   // Any other immediate is a plain nop
   typedef enum logic [15:0] {
      CMD_EXIT   = 16'h0001,
      CMD_REPORT = 16'h0002,
      CMD_PUTC   = 16'h0004
   } sim_cmd_e;

   // One decoded command, 57 bits
   typedef struct packed {
      logic                 valid;
      sim_cmd_e             cmd;
      logic [CORE_ID_W-1:0] core;
      // r3 as seen by the command
      logic [31:0]          data;
   } sim_event_t;

   // Exit notice from a decoder to the termination stage
   typedef struct packed {
      logic        valid;
      logic [31:0] code;
   } exit_t;

endpackage

`default_nettype wire
